// File: common/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// client side widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// strobes are byte masks of one beat
`define BUS_STRB_W 8

// master data path holds two client words per beat
`define BUS_BEAT_W 64

// mtime words served without the bus
`define BUS_RTC_ADDR    32'h0200_bff8
`define BUS_RTC_ADDR_UP 32'h0200_bffc

`endif

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

  typedef enum logic [2:0] {
    ST_IF_ADDR  = 3'd0,
    ST_IF_DATA  = 3'd1,
    ST_LS_ADDR  = 3'd2,
    ST_LS_RDATA = 3'd3,
    ST_LS_WDATA = 3'd4
  } arb_state_t;

  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  localparam axi_size_t AXI_SIZE_1B = 3'd0;
  localparam axi_size_t AXI_SIZE_2B = 3'd1;
  localparam axi_size_t AXI_SIZE_4B = 3'd2;

  // only the three aligned masks of the lsu are known
  function automatic axi_size_t strb_to_size(input logic [7:0] strb);
    case (strb)
      8'h01: return AXI_SIZE_1B;
      8'h03: return AXI_SIZE_2B;
      8'h0f: return AXI_SIZE_4B;
      default: return AXI_SIZE_1B;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: rtl/bus_arbiter_fsm.sv
`timescale 1ns/10ps
`default_nettype none
`include "bus_settings.svh"

module bus_arbiter_fsm (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     ifu_arvalid_i,
  input  wire                     lsu_arvalid_i,
  input  wire                     lsu_awvalid_i,
  input  wire                     lsu_wvalid_i,
  input  wire [`BUS_ADDR_W-1:0]   ifu_araddr_i,
  input  wire [`BUS_ADDR_W-1:0]   lsu_araddr_i,
  input  wire                     m_arready_i,
  input  wire                     m_rvalid_i,
  input  wire bus_pkg::axi_resp_t m_rresp_i,
  input  wire                     m_awready_i,
  input  wire                     m_wready_i,
  input  wire                     m_bvalid_i,
  input  wire bus_pkg::axi_resp_t m_bresp_i,
  output logic                    m_arvalid_o,
  output logic                    m_awvalid_o,
  output logic                    m_wvalid_o,
  output logic                    m_wlast_o,
  output logic                    m_rready_o,
  output logic                    m_bready_o,
  output logic [`BUS_ADDR_W-1:0]  araddr_o,
  output logic                    ifu_rvalid_o,
  output logic                    bus_lsu_rvalid_o,
  output logic                    lsu_wready_o,
  output logic                    timer_rd_o
);
  import bus_pkg::*;

  arb_state_t state_q;
  arb_state_t state_d;
  logic       w_sent_q;    // single W beat already accepted
  logic       ar_wait_q;   // fetch AR raised but not yet taken
  logic       timer_hit;
  logic       ls_pending;
  logic       fetch_go;

  assign timer_hit  = (lsu_araddr_i == `BUS_RTC_ADDR) || (lsu_araddr_i == `BUS_RTC_ADDR_UP);
  assign ls_pending = lsu_arvalid_i || lsu_awvalid_i;
  // lsu wins unless a fetch AR is already on the bus
  assign fetch_go   = ifu_arvalid_i && (ar_wait_q || !ls_pending);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IF_ADDR:
      begin
        if (fetch_go)
        begin
          if (m_arready_i)
            state_d = ST_IF_DATA;
        end
        else if (ls_pending)
          state_d = ST_LS_ADDR;
      end
      ST_IF_DATA:
      begin
        if (m_rvalid_i)
          state_d = ls_pending ? ST_LS_ADDR : ST_IF_ADDR;
      end
      ST_LS_ADDR:
      begin
        if (lsu_arvalid_i)
        begin
          if (timer_hit)
            state_d = ST_IF_ADDR;   // mtime answers next cycle
          else if (m_arready_i)
            state_d = ST_LS_RDATA;
        end
        else if (lsu_awvalid_i)
        begin
          if (m_awready_i)
            state_d = ST_LS_WDATA;
        end
        else
          state_d = ST_IF_ADDR;     // request already gone
      end
      ST_LS_RDATA:
      begin
        if (m_rvalid_i)
          state_d = ST_IF_ADDR;
      end
      ST_LS_WDATA:
      begin
        if (m_bvalid_i)
          state_d = ST_IF_ADDR;
      end
      default: state_d = ST_IF_ADDR;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= ST_IF_ADDR;
      w_sent_q  <= 1'b0;
      ar_wait_q <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      ar_wait_q <= (state_q == ST_IF_ADDR) && m_arvalid_o && !m_arready_i;
      if (state_q != ST_LS_WDATA)
        w_sent_q <= 1'b0;
      else if (m_wvalid_o && m_wready_i)
        w_sent_q <= 1'b1;
    end
  end

  assign m_arvalid_o = ((state_q == ST_IF_ADDR) && fetch_go) ||
                       ((state_q == ST_LS_ADDR) && lsu_arvalid_i && !timer_hit);
  assign m_awvalid_o = (state_q == ST_LS_ADDR) && !lsu_arvalid_i && lsu_awvalid_i;
  assign m_wvalid_o  = (state_q == ST_LS_WDATA) && lsu_wvalid_i && !w_sent_q;
  assign m_wlast_o   = m_wvalid_o;   // one beat bursts
  assign m_rready_o  = 1'b1;
  assign m_bready_o  = 1'b1;

  assign araddr_o = ((state_q == ST_LS_ADDR) || (state_q == ST_LS_RDATA)) ?
                    lsu_araddr_i : ifu_araddr_i;

  assign ifu_rvalid_o     = (state_q == ST_IF_DATA) && m_rvalid_i;
  assign bus_lsu_rvalid_o = (state_q == ST_LS_RDATA) && m_rvalid_i;
  assign lsu_wready_o     = (state_q == ST_LS_WDATA) && m_bvalid_i;
  assign timer_rd_o       = (state_q == ST_LS_ADDR) && lsu_arvalid_i && timer_hit;

  a_ar_aw_excl: assert property (@(posedge clk) disable iff (rst)
    !(m_arvalid_o && m_awvalid_o));

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state_q inside {ST_IF_ADDR, ST_IF_DATA, ST_LS_ADDR, ST_LS_RDATA, ST_LS_WDATA});

  // clients must hold address until accepted
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(araddr_o));

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rresp_i == AXI_RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_bresp_i == AXI_RESP_OKAY);

endmodule

`default_nettype wire

// File: rtl/mtime_counter.sv
`timescale 1ns/10ps
`default_nettype none
`include "bus_settings.svh"

module mtime_counter (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    rd_i,
  input  wire                    rd_hi_i,    // upper word of mtime
  output logic [`BUS_DATA_W-1:0] rdata_o,
  output logic                   rvalid_o
);

  logic [2*`BUS_DATA_W-1:0] mtime_q;

  // free running count of clk cycles
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= '0;
    else
      mtime_q <= mtime_q + 1'b1;
  end

  // read answers one cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_o <= 1'b0;
    else
      rvalid_o <= rd_i;
  end

  // count as seen in the response cycle
  assign rdata_o = rd_hi_i ? mtime_q[2*`BUS_DATA_W-1:`BUS_DATA_W] : mtime_q[`BUS_DATA_W-1:0];

endmodule

`default_nettype wire

// File: rtl/read_lane_mux.sv
`timescale 1ns/10ps
`default_nettype none
`include "bus_settings.svh"

module read_lane_mux (
  input  wire [`BUS_BEAT_W-1:0]  m_rdata_i,
  input  wire [`BUS_ADDR_W-1:0]  araddr_i,
  input  wire [`BUS_STRB_W-1:0]  lsu_rstrb_i,
  input  wire                    bus_lsu_rvalid_i,
  input  wire [`BUS_DATA_W-1:0]  mtime_rdata_i,
  input  wire                    mtime_rvalid_i,
  output logic [`BUS_DATA_W-1:0] ifu_rdata_o,
  output logic [`BUS_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_rvalid_o,
  output bus_pkg::axi_size_t     m_arsize_o
);
  import bus_pkg::*;

  logic [`BUS_DATA_W-1:0] beat_word;

  // bit 2 picks the word inside the beat
  assign beat_word = araddr_i[2] ? m_rdata_i[`BUS_BEAT_W-1:`BUS_DATA_W] :
                                   m_rdata_i[`BUS_DATA_W-1:0];

  assign ifu_rdata_o = beat_word;

  // timer and bus never answer in the same cycle
  assign lsu_rdata_o  = mtime_rvalid_i ? mtime_rdata_i : beat_word;
  assign lsu_rvalid_o = bus_lsu_rvalid_i || mtime_rvalid_i;

  assign m_arsize_o = strb_to_size(lsu_rstrb_i);

endmodule

`default_nettype wire

// File: rtl/write_lane_align.sv
`timescale 1ns/10ps
`default_nettype none
`include "bus_settings.svh"

module write_lane_align (
  input  wire [`BUS_ADDR_W-1:0]  awaddr_i,
  input  wire [`BUS_DATA_W-1:0]  wdata_i,
  input  wire [`BUS_STRB_W-1:0]  wstrb_i,
  output logic [`BUS_BEAT_W-1:0] m_wdata_o,
  output logic [`BUS_STRB_W-1:0] m_wstrb_o,
  output bus_pkg::axi_size_t     m_awsize_o
);
  import bus_pkg::*;

  logic [1:0]             byte_off;
  logic [`BUS_DATA_W-1:0] wdata_sh;
  logic [3:0]             wstrb_sh;

  assign byte_off = awaddr_i[1:0];

  // move bytes up to their lane within the word
  assign wdata_sh = wdata_i << {byte_off, 3'b000};
  assign wstrb_sh = wstrb_i[3:0] << byte_off;   // upper bits fall off

  // same data on both halves while the strobe picks the lane
  assign m_wdata_o = {wdata_sh, wdata_sh};
  assign m_wstrb_o = awaddr_i[2] ? {wstrb_sh, 4'b0000} : {4'b0000, wstrb_sh};

  assign m_awsize_o = strb_to_size(wstrb_i);

endmodule

`default_nettype wire

// File: rtl/mem_bus_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "bus_settings.svh"

module mem_bus_top (
  input  wire                     clk,
  input  wire                     rst,
  // fetch
  input  wire                     ifu_arvalid_i,
  input  wire [`BUS_ADDR_W-1:0]   ifu_araddr_i,
  output wire [`BUS_DATA_W-1:0]   ifu_rdata_o,
  output wire                     ifu_rvalid_o,
  // load
  input  wire                     lsu_arvalid_i,
  input  wire [`BUS_ADDR_W-1:0]   lsu_araddr_i,
  input  wire [`BUS_STRB_W-1:0]   lsu_rstrb_i,
  output wire [`BUS_DATA_W-1:0]   lsu_rdata_o,
  output wire                     lsu_rvalid_o,
  // store
  input  wire                     lsu_awvalid_i,
  input  wire [`BUS_ADDR_W-1:0]   lsu_awaddr_i,
  input  wire                     lsu_wvalid_i,
  input  wire [`BUS_DATA_W-1:0]   lsu_wdata_i,
  input  wire [`BUS_STRB_W-1:0]   lsu_wstrb_i,
  output wire                     lsu_wready_o,
  // master AR / R
  output wire                     m_arvalid_o,
  input  wire                     m_arready_i,
  output wire [`BUS_ADDR_W-1:0]   m_araddr_o,
  output wire bus_pkg::axi_size_t m_arsize_o,
  input  wire                     m_rvalid_i,
  output wire                     m_rready_o,
  input  wire [`BUS_BEAT_W-1:0]   m_rdata_i,
  input  wire bus_pkg::axi_resp_t m_rresp_i,
  // master AW / W / B
  output wire                     m_awvalid_o,
  input  wire                     m_awready_i,
  output wire [`BUS_ADDR_W-1:0]   m_awaddr_o,
  output wire bus_pkg::axi_size_t m_awsize_o,
  output wire                     m_wvalid_o,
  input  wire                     m_wready_i,
  output wire [`BUS_BEAT_W-1:0]   m_wdata_o,
  output wire [`BUS_STRB_W-1:0]   m_wstrb_o,
  output wire                     m_wlast_o,
  input  wire                     m_bvalid_i,
  output wire                     m_bready_o,
  input  wire bus_pkg::axi_resp_t m_bresp_i
);

  wire                   bus_lsu_rvalid;
  wire                   timer_rd;
  wire [`BUS_DATA_W-1:0] mtime_rdata;
  wire                   mtime_rvalid;

  assign m_awaddr_o = lsu_awaddr_i;

  bus_arbiter_fsm i_fsm (
    .clk              (clk),
    .rst              (rst),
    .ifu_arvalid_i    (ifu_arvalid_i),
    .lsu_arvalid_i    (lsu_arvalid_i),
    .lsu_awvalid_i    (lsu_awvalid_i),
    .lsu_wvalid_i     (lsu_wvalid_i),
    .ifu_araddr_i     (ifu_araddr_i),
    .lsu_araddr_i     (lsu_araddr_i),
    .m_arready_i      (m_arready_i),
    .m_rvalid_i       (m_rvalid_i),
    .m_rresp_i        (m_rresp_i),
    .m_awready_i      (m_awready_i),
    .m_wready_i       (m_wready_i),
    .m_bvalid_i       (m_bvalid_i),
    .m_bresp_i        (m_bresp_i),
    .m_arvalid_o      (m_arvalid_o),
    .m_awvalid_o      (m_awvalid_o),
    .m_wvalid_o       (m_wvalid_o),
    .m_wlast_o        (m_wlast_o),
    .m_rready_o       (m_rready_o),
    .m_bready_o       (m_bready_o),
    .araddr_o         (m_araddr_o),
    .ifu_rvalid_o     (ifu_rvalid_o),
    .bus_lsu_rvalid_o (bus_lsu_rvalid),
    .lsu_wready_o     (lsu_wready_o),
    .timer_rd_o       (timer_rd)
  );

  // load address is still held when the timer answers
  mtime_counter i_mtime (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (timer_rd),
    .rd_hi_i  (lsu_araddr_i[2]),
    .rdata_o  (mtime_rdata),
    .rvalid_o (mtime_rvalid)
  );

  read_lane_mux i_rd_lane (
    .m_rdata_i        (m_rdata_i),
    .araddr_i         (m_araddr_o),
    .lsu_rstrb_i      (lsu_rstrb_i),
    .bus_lsu_rvalid_i (bus_lsu_rvalid),
    .mtime_rdata_i    (mtime_rdata),
    .mtime_rvalid_i   (mtime_rvalid),
    .ifu_rdata_o      (ifu_rdata_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_rvalid_o     (lsu_rvalid_o),
    .m_arsize_o       (m_arsize_o)
  );

  write_lane_align i_wr_lane (
    .awaddr_i   (lsu_awaddr_i),
    .wdata_i    (lsu_wdata_i),
    .wstrb_i    (lsu_wstrb_i),
    .m_wdata_o  (m_wdata_o),
    .m_wstrb_o  (m_wstrb_o),
    .m_awsize_o (m_awsize_o)
  );

endmodule

`default_nettype wire

// File: test/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model (
  input  wire         clk,
  input  wire         rst,
  input  wire         arvalid_i,
  input  wire  [31:0] araddr_i,
  output logic        arready_o,
  output logic        rvalid_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  input  wire         awvalid_i,
  input  wire  [31:0] awaddr_i,
  output logic        awready_o,
  input  wire         wvalid_i,
  input  wire  [63:0] wdata_i,
  input  wire  [7:0]  wstrb_i,
  output logic        wready_o,
  output logic        bvalid_o,
  output logic [1:0]  bresp_o
);

  logic [31:0] mem [logic [29:0]];   // only written words are stored
  integer      seed = 32'hfcbf49d4;
  logic [31:0] r_addr;
  logic [31:0] w_addr;
  logic        rpend;
  logic        wpend;
  logic [1:0]  ar_dly;
  logic [1:0]  r_dly;
  logic [1:0]  aw_dly;
  logic [1:0]  w_dly;
  logic [31:0] wa;
  logic [31:0] word;

  // untouched words hold their address xor a fixed pattern
  function automatic logic [31:0] read_word(input logic [31:0] a);
    if (mem.exists(a[31:2]))
      return mem[a[31:2]];
    return {a[31:2], 2'b00} ^ 32'h5a5a_5a5a;
  endfunction

  assign rresp_o = 2'b00;
  assign bresp_o = 2'b00;

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rpend     <= 1'b0;
      wpend     <= 1'b0;
      ar_dly    <= 2'd0;
      aw_dly    <= 2'd0;
      r_dly     <= 2'd0;
      w_dly     <= 2'd0;
    end
    else
    begin
      if (arvalid_i && arready_o)
      begin
        arready_o <= 1'b0;
        r_addr    <= araddr_i;
        rpend     <= 1'b1;
        r_dly     <= 2'($random(seed));
        ar_dly    <= 2'($random(seed));
      end
      else if (arvalid_i && !rpend && !rvalid_o)
      begin
        if (ar_dly == 2'd0)
          arready_o <= 1'b1;
        else
          ar_dly <= ar_dly - 2'd1;
      end
      if (rvalid_o)
        rvalid_o <= 1'b0;   // rready is always high
      else if (rpend)
      begin
        if (r_dly == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= {read_word({r_addr[31:3], 3'b100}), read_word({r_addr[31:3], 3'b000})};
          rpend    <= 1'b0;
        end
        else
          r_dly <= r_dly - 2'd1;
      end

      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        w_addr    <= awaddr_i;
        wpend     <= 1'b1;
        aw_dly    <= 2'($random(seed));
      end
      else if (awvalid_i && !wpend && !bvalid_o)
      begin
        if (aw_dly == 2'd0)
          awready_o <= 1'b1;
        else
          aw_dly <= aw_dly - 2'd1;
      end
      if (bvalid_o)
        bvalid_o <= 1'b0;
      if (wvalid_i && wready_o)
      begin
        // byte merge over the whole beat
        for (int i = 0; i < 8; i++)
        begin
          if (wstrb_i[i])
          begin
            wa = {w_addr[31:3], 3'b000} + ((i >= 4) ? 32'd4 : 32'd0);
            word = read_word(wa);
            word[(i % 4) * 8 +: 8] = wdata_i[i * 8 +: 8];
            mem[wa[31:2]] = word;
          end
        end
        wready_o <= 1'b0;
        wpend    <= 1'b0;
        bvalid_o <= 1'b1;
        w_dly    <= 2'($random(seed));
      end
      else if (wvalid_i && wpend)
      begin
        if (w_dly == 2'd0)
          wready_o <= 1'b1;
        else
          w_dly <= w_dly - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_mem_bus.sv
`timescale 1ns/10ps
`default_nettype none
`include "bus_settings.svh"

module tb_mem_bus;

  localparam int N_ROWS = 16;
  localparam logic [1:0] OP_FETCH = 2'd0;
  localparam logic [1:0] OP_LOAD  = 2'd1;
  localparam logic [1:0] OP_STORE = 2'd2;
  localparam logic [1:0] OP_BOTH  = 2'd3;   // wdata column holds the fetch address

  logic        clk;
  logic        rst;
  logic        ifu_arvalid;
  logic [31:0] ifu_araddr;
  logic        lsu_arvalid;
  logic [31:0] lsu_araddr;
  logic [7:0]  lsu_rstrb;
  logic        lsu_awvalid;
  logic [31:0] lsu_awaddr;
  logic        lsu_wvalid;
  logic [31:0] lsu_wdata;
  logic [7:0]  lsu_wstrb;
  wire  [31:0] ifu_rdata;
  wire         ifu_rvalid;
  wire  [31:0] lsu_rdata;
  wire         lsu_rvalid;
  wire         lsu_wready;
  wire         m_arvalid;
  wire         m_arready;
  wire  [31:0] m_araddr;
  wire  [2:0]  m_arsize;
  wire         m_rvalid;
  wire         m_rready;
  wire  [63:0] m_rdata;
  wire  [1:0]  m_rresp;
  wire         m_awvalid;
  wire         m_awready;
  wire  [31:0] m_awaddr;
  wire  [2:0]  m_awsize;
  wire         m_wvalid;
  wire         m_wready;
  wire  [63:0] m_wdata;
  wire  [7:0]  m_wstrb;
  wire         m_wlast;
  wire         m_bvalid;
  wire         m_bready;
  wire  [1:0]  m_bresp;

  logic [1:0]  tbl_op    [N_ROWS];
  logic [31:0] tbl_addr  [N_ROWS];
  logic [7:0]  tbl_strb  [N_ROWS];
  logic [31:0] tbl_wdata [N_ROWS];
  logic [31:0] tbl_exp   [N_ROWS];
  int          n_rows;
  int          err_cnt;
  int          store_cnt;
  int          wready_cnt;
  logic [63:0] cyc;   // cycles since reset release

  mem_bus_top i_dut (
    .clk (clk), .rst (rst),
    .ifu_arvalid_i (ifu_arvalid), .ifu_araddr_i (ifu_araddr),
    .ifu_rdata_o (ifu_rdata), .ifu_rvalid_o (ifu_rvalid),
    .lsu_arvalid_i (lsu_arvalid), .lsu_araddr_i (lsu_araddr), .lsu_rstrb_i (lsu_rstrb),
    .lsu_rdata_o (lsu_rdata), .lsu_rvalid_o (lsu_rvalid),
    .lsu_awvalid_i (lsu_awvalid), .lsu_awaddr_i (lsu_awaddr), .lsu_wvalid_i (lsu_wvalid),
    .lsu_wdata_i (lsu_wdata), .lsu_wstrb_i (lsu_wstrb), .lsu_wready_o (lsu_wready),
    .m_arvalid_o (m_arvalid), .m_arready_i (m_arready), .m_araddr_o (m_araddr),
    .m_arsize_o (m_arsize), .m_rvalid_i (m_rvalid), .m_rready_o (m_rready),
    .m_rdata_i (m_rdata), .m_rresp_i (m_rresp),
    .m_awvalid_o (m_awvalid), .m_awready_i (m_awready), .m_awaddr_o (m_awaddr),
    .m_awsize_o (m_awsize), .m_wvalid_o (m_wvalid), .m_wready_i (m_wready),
    .m_wdata_o (m_wdata), .m_wstrb_o (m_wstrb), .m_wlast_o (m_wlast),
    .m_bvalid_i (m_bvalid), .m_bready_o (m_bready), .m_bresp_i (m_bresp)
  );

  axi_mem_model i_mem (
    .clk (clk), .rst (rst),
    .arvalid_i (m_arvalid), .araddr_i (m_araddr), .arready_o (m_arready),
    .rvalid_o (m_rvalid), .rdata_o (m_rdata), .rresp_o (m_rresp),
    .awvalid_i (m_awvalid), .awaddr_i (m_awaddr), .awready_o (m_awready),
    .wvalid_i (m_wvalid), .wdata_i (m_wdata), .wstrb_i (m_wstrb), .wready_o (m_wready),
    .bvalid_o (m_bvalid), .bresp_o (m_bresp)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (rst)
      cyc <= 64'd0;
    else
      cyc <= cyc + 64'd1;
  end

  always @(negedge clk)
  begin
    if (!rst && lsu_wready)
      wready_cnt++;
  end

  initial
  begin
    #((N_ROWS * 200 + 16) * 10);
    $display("Timeout: a response never arrived");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic expect_true(input logic ok, input string msg);
    assert (ok) else
    begin
      err_cnt++;
      $display("Error: %0t ns: %s", $time, msg);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] word_pattern(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic [2:0] size_for_strb(input logic [7:0] strb);
    case (strb)
      8'h01: return 3'd0;
      8'h03: return 3'd1;
      8'h0f: return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

  task automatic add_row(input logic [1:0] op, input logic [31:0] addr, input logic [7:0] strb,
                         input logic [31:0] wdata, input logic [31:0] exp);
    tbl_op[n_rows]    = op;
    tbl_addr[n_rows]  = addr;
    tbl_strb[n_rows]  = strb;
    tbl_wdata[n_rows] = wdata;
    tbl_exp[n_rows]   = exp;
    n_rows++;
  endtask

  task automatic fetch_word(input logic [31:0] addr, input logic [31:0] exp);
    ifu_arvalid = 1'b1;
    ifu_araddr  = addr;
    do
      @(negedge clk);
    while (!ifu_rvalid);
    expect_true(m_rready, "rready low while the fetch response is valid");
    expect_true(ifu_rdata == exp,
                $sformatf("fetch %h returned %h, expected %h", addr, ifu_rdata, exp));
    ifu_arvalid = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [7:0] strb,
                           input logic [31:0] exp);
    logic timer;
    int   lat;
    timer = (addr == `BUS_RTC_ADDR) || (addr == `BUS_RTC_ADDR_UP);
    lat = 0;
    lsu_arvalid = 1'b1;
    lsu_araddr  = addr;
    lsu_rstrb   = strb;
    do
    begin
      @(negedge clk);
      lat++;
      if (m_arvalid)
      begin
        expect_true(!timer, $sformatf("arvalid raised for timer read %h", addr));
        expect_true(m_araddr == addr, $sformatf("araddr %h, expected %h", m_araddr, addr));
        expect_true(m_arsize == size_for_strb(strb),
                    $sformatf("arsize %0d for strobe %h", m_arsize, strb));
      end
    end
    while (!lsu_rvalid);
    if (timer)
    begin
      // one cycle for the fsm to take the request and one for the counter
      expect_true(lat == 2, $sformatf("timer read answered after %0d cycles", lat));
      exp = (addr == `BUS_RTC_ADDR) ? cyc[31:0] : 32'd0;
    end
    expect_true(lsu_rdata == exp,
                $sformatf("load %h returned %h, expected %h", addr, lsu_rdata, exp));
    lsu_arvalid = 1'b0;
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [7:0] strb,
                            input logic [31:0] wdata);
    logic [31:0] sh;
    logic [3:0]  st;
    logic [7:0]  exp_strb;
    logic        aw_stall;
    logic        w_stall;
    sh = wdata << (8 * addr[1:0]);
    st = strb[3:0] << addr[1:0];
    exp_strb = addr[2] ? {st, 4'b0000} : {4'b0000, st};
    aw_stall = 1'b0;
    w_stall  = 1'b0;
    lsu_awvalid = 1'b1;
    lsu_wvalid  = 1'b1;
    lsu_awaddr  = addr;
    lsu_wdata   = wdata;
    lsu_wstrb   = strb;
    do
    begin
      @(negedge clk);
      if (aw_stall)
        expect_true(m_awvalid, "awvalid dropped before awready");
      if (w_stall)
        expect_true(m_wvalid, "wvalid dropped before wready");
      if (m_awvalid)
      begin
        expect_true(m_awaddr == addr, $sformatf("awaddr %h, expected %h", m_awaddr, addr));
        expect_true(m_awsize == size_for_strb(strb),
                    $sformatf("awsize %0d for strobe %h", m_awsize, strb));
      end
      if (m_wvalid)
      begin
        expect_true(m_wdata == {sh, sh}, $sformatf("wdata %h for store %h", m_wdata, addr));
        expect_true(m_wstrb == exp_strb,
                    $sformatf("wstrb %h, expected %h", m_wstrb, exp_strb));
        expect_true(m_wlast, "wlast low with wvalid");
      end
      aw_stall = m_awvalid && !m_awready;
      w_stall  = m_wvalid && !m_wready;
    end
    while (!lsu_wready);
    expect_true(m_bready, "bready low while the write response is valid");
    lsu_awvalid = 1'b0;
    lsu_wvalid  = 1'b0;
    store_cnt++;
  endtask

  task automatic load_during_fetch(input logic [31:0] laddr, input logic [31:0] faddr,
                                   input logic [31:0] exp);
    logic first_ar;
    logic got_f;
    logic got_l;
    first_ar = 1'b1;
    got_f = 1'b0;
    got_l = 1'b0;
    ifu_arvalid = 1'b1;
    ifu_araddr  = faddr;
    lsu_arvalid = 1'b1;
    lsu_araddr  = laddr;
    lsu_rstrb   = 8'h0f;
    while (!(got_f && got_l))
    begin
      @(negedge clk);
      if (m_arvalid && first_ar)
      begin
        expect_true(m_araddr == laddr, $sformatf("first AR went to %h, not load", m_araddr));
        first_ar = 1'b0;
      end
      if (lsu_rvalid)
      begin
        expect_true(lsu_rdata == exp, $sformatf("load %h returned %h", laddr, lsu_rdata));
        got_l = 1'b1;
        lsu_arvalid = 1'b0;
      end
      if (ifu_rvalid)
      begin
        expect_true(got_l, "fetch answered before the load");
        expect_true(ifu_rdata == word_pattern(faddr),
                    $sformatf("fetch %h returned %h", faddr, ifu_rdata));
        got_f = 1'b1;
        ifu_arvalid = 1'b0;
      end
    end
  endtask

  initial
  begin
    rst = 1'b1;
    ifu_arvalid = 1'b0;
    ifu_araddr  = 32'd0;
    lsu_arvalid = 1'b0;
    lsu_araddr  = 32'd0;
    lsu_rstrb   = 8'd0;
    lsu_awvalid = 1'b0;
    lsu_awaddr  = 32'd0;
    lsu_wvalid  = 1'b0;
    lsu_wdata   = 32'd0;
    lsu_wstrb   = 8'd0;
    n_rows = 0;
    err_cnt = 0;
    store_cnt = 0;
    wready_cnt = 0;

    add_row(OP_FETCH, 32'h8000_0000, 8'h0f, 32'd0, 32'hda5a_5a5a);
    add_row(OP_FETCH, 32'h8000_0004, 8'h0f, 32'd0, 32'hda5a_5a5e);
    add_row(OP_LOAD,  32'h8000_0010, 8'h01, 32'd0, 32'hda5a_5a4a);
    add_row(OP_LOAD,  32'h8000_0014, 8'h03, 32'd0, 32'hda5a_5a4e);
    add_row(OP_LOAD,  32'h8000_0008, 8'h0f, 32'd0, 32'hda5a_5a52);
    add_row(OP_STORE, 32'h8000_0020, 8'h01, 32'h0000_0011, 32'd0);
    add_row(OP_STORE, 32'h8000_0021, 8'h01, 32'h0000_0022, 32'd0);
    add_row(OP_STORE, 32'h8000_0022, 8'h03, 32'h0000_4433, 32'd0);
    add_row(OP_LOAD,  32'h8000_0020, 8'h0f, 32'd0, 32'h4433_2211);
    add_row(OP_STORE, 32'h8000_0027, 8'h01, 32'h0000_0099, 32'd0);
    add_row(OP_LOAD,  32'h8000_0024, 8'h0f, 32'd0, 32'h995a_5a7e);
    add_row(OP_BOTH,  32'h8000_0034, 8'h0f, 32'h8000_0030, 32'hda5a_5a6e);
    add_row(OP_LOAD,  `BUS_RTC_ADDR, 8'h0f, 32'd0, 32'd0);
    add_row(OP_LOAD,  `BUS_RTC_ADDR_UP, 8'h0f, 32'd0, 32'd0);
    add_row(OP_STORE, 32'h8000_0040, 8'h0f, 32'hcafe_f00d, 32'd0);
    add_row(OP_LOAD,  32'h8000_0040, 8'h0f, 32'd0, 32'hcafe_f00d);

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int r = 0; r < n_rows; r++)
    begin
      case (tbl_op[r])
        OP_FETCH: fetch_word(tbl_addr[r], tbl_exp[r]);
        OP_LOAD:  load_word(tbl_addr[r], tbl_strb[r], tbl_exp[r]);
        OP_STORE: store_word(tbl_addr[r], tbl_strb[r], tbl_wdata[r]);
        default:  load_during_fetch(tbl_addr[r], tbl_wdata[r], tbl_exp[r]);
      endcase
    end

    repeat (4) @(negedge clk);
    expect_true(wready_cnt == store_cnt,
                $sformatf("%0d wready pulses for %0d stores", wready_cnt, store_cnt));

    if (err_cnt == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("STATUS: FAIL");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/bus_pkg.sv
rtl/bus_arbiter_fsm.sv
rtl/mtime_counter.sv
rtl/read_lane_mux.sv
rtl/write_lane_align.sv
rtl/mem_bus_top.sv
test/axi_mem_model.sv
test/tb_mem_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_mem_bus \
  -o sim_tb

# the log decides pass or fail
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
else
  exit 1
fi
